//--- Bender.yml
package:
  name: wvb_readout

sources:
  - logic/wvb_pkg.sv
  - logic/wvb_hdr_fifo.sv
  - logic/wvb_buffer.sv
  - logic/wvb_rd_ctrl_fmt_0.sv
  - logic/wvb_reader.sv
  - logic/dpram_readout.sv
  - logic/wvb_readout_top.sv
  - target: test
    files:
      - testbench/wvb_readout_tb.sv

//--- filelist.f
logic/wvb_pkg.sv
logic/wvb_hdr_fifo.sv
logic/wvb_buffer.sv
logic/wvb_rd_ctrl_fmt_0.sv
logic/wvb_reader.sv
logic/dpram_readout.sv
logic/wvb_readout_top.sv
testbench/wvb_readout_tb.sv

//--- logic/dpram_readout.sv
// readout DPRAM with a 1024x32 write port and a registered 2048x16 read port
`timescale 1ns/10ps
`default_nettype none

module dpram_readout
  import wvb_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        wren,
  input  wire dpram_addr_t wr_addr,
  input  wire dpram_word_t wr_data,
  input  wire rd_addr_t    rd_addr,
  output rd_word_t         rd_data
);

  dpram_word_t mem [2**$bits(dpram_addr_t)];
  dpram_word_t rd_word;

  // upper address bits pick the 32-bit word
  assign rd_word = mem[rd_addr[10:1]];

  always_ff @(posedge clk) begin
    if (wren) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // low half at even addresses
  always_ff @(posedge clk) begin
    rd_data <= rd_addr[0] ? rd_word[31:16] : rd_word[15:0];
  end

endmodule

`default_nettype wire

//--- logic/wvb_buffer.sv
// circular sample memory with event tracking, header bundle assembly and 4-stage read pipeline
`timescale 1ns/10ps
`default_nettype none

module wvb_buffer
  import wvb_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        sample_wr,
  input  wire wvb_sample_t sample_data,
  input  wire logic        evt_end,
  input  wire ltc_t        ltc,
  input  wire logic [1:0]  trig_type,
  input  wire logic        cnst_run,
  input  wire logic [4:0]  pre_conf,
  input  wire logic        wvb_rdreq,
  input  wire logic        wvb_rddone,
  output wvb_sample_t      wvb_data,
  output wvb_hdr_t         hdr_data,
  output logic             hdr_avail
);

  wvb_sample_t mem [2**wvb_addr_w];

  // write side
  wvb_addr_t wr_addr;
  wvb_addr_t start_addr;
  wvb_addr_t evt_start;
  logic in_evt;
  logic wr_ok;
  logic hdr_full;
  wvb_hdr_t hdr_bundle;

  // read side
  wvb_addr_t rd_addr;
  // first address still owned by an unread event
  wvb_addr_t rel_addr;
  wvb_addr_t head_stop;
  wvb_addr_t rd_a0;
  wvb_addr_t rd_a1;
  wvb_sample_t rd_d2;

  // drop a sample that would overwrite unread data, or whose header could not be kept
  assign wr_ok = sample_wr && !hdr_full && ((wr_addr + 1'b1) != rel_addr);

  // a single-sample event starts at its own address
  assign evt_start = in_evt ? start_addr : wr_addr;
  assign hdr_bundle = {ltc, evt_start, wr_addr, pre_conf, cnst_run, trig_type};

  assign head_stop = hdr_data[19:8];

  wvb_hdr_fifo hdr_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (evt_end && wr_ok),
    .push_data (hdr_bundle),
    .pop       (wvb_rddone),
    .head      (hdr_data),
    .not_empty (hdr_avail),
    .full      (hdr_full)
  );

  // write pointer and event start tracking
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr <= '0;
      in_evt <= 1'b0;
    end else if (wr_ok) begin
      wr_addr <= wr_addr + 1'b1;
      if (evt_end) begin
        in_evt <= 1'b0;
      end else if (!in_evt) begin
        // first sample after an event end
        in_evt <= 1'b1;
        start_addr <= wr_addr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_addr] <= sample_data;
    end
  end

  // read address, realigned to the next event on rddone
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr <= '0;
      rel_addr <= '0;
    end else if (wvb_rddone) begin
      rd_addr <= head_stop + 1'b1;
      rel_addr <= head_stop + 1'b1;
    end else if (wvb_rdreq) begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  // address, address, memory, output stages
  // without rdreq the pipeline keeps showing the next unread sample
  always_ff @(posedge clk) begin
    rd_a0 <= rd_addr;
    rd_a1 <= rd_a0;
    if (wvb_rddone) begin
      // flush data in flight past the event end
      rd_d2 <= '0;
      wvb_data <= '0;
    end else begin
      rd_d2 <= mem[rd_a1];
      wvb_data <= rd_d2;
    end
  end

endmodule

`default_nettype wire

//--- logic/wvb_hdr_fifo.sv
// header bundle FIFO with first-word fall-through
`timescale 1ns/10ps
`default_nettype none

module wvb_hdr_fifo
  import wvb_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     push,
  input  wire wvb_hdr_t push_data,
  input  wire logic     pop,
  output wvb_hdr_t      head,
  output logic          not_empty,
  output logic          full
);

  wvb_hdr_t mem [hdr_fifo_depth];
  logic [hdr_fifo_ptr_w-1:0] wr_ptr;
  logic [hdr_fifo_ptr_w-1:0] rd_ptr;
  // one extra bit to tell full from empty
  logic [hdr_fifo_ptr_w:0] count;
  logic do_push;
  logic do_pop;

  // pushes into a full FIFO and pops of an empty one are ignored
  assign do_push = push && !full;
  assign do_pop = pop && not_empty;

  // head entry shows without a pop
  assign head = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign full = (count == (hdr_fifo_ptr_w + 1)'(hdr_fifo_depth));

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      // pointers wrap on their own at a power-of-two depth
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/wvb_pkg.sv
// widths, format constants, vector typedefs and FSM state enums of the waveform readout path
package wvb_pkg;

  // sample memory address width
  localparam int wvb_addr_w = 12;

  typedef logic [wvb_addr_w-1:0] wvb_addr_t;
  // discr[21:14], adc[13:2], tot[1], eoe[0]
  typedef logic [21:0] wvb_sample_t;
  // ltc, start, stop, pre_conf, cnst_run, trig type from the top bit down
  typedef logic [79:0] wvb_hdr_t;
  typedef logic [47:0] ltc_t;
  typedef logic [15:0] evt_len_t;
  typedef logic [9:0] dpram_addr_t;
  typedef logic [31:0] dpram_word_t;
  typedef logic [10:0] rd_addr_t;
  typedef logic [15:0] rd_word_t;
  typedef logic [7:0] chan_t;

  // format byte of the channel word
  localparam logic [7:0] fmt_code = 8'h90;

  // DPRAM word addresses where the controller changes behavior
  localparam dpram_addr_t dpram_a_stop_stream = 10'd1017;
  localparam dpram_addr_t dpram_a_last_data = 10'd1021;
  localparam dpram_addr_t dpram_a_last_data_continue = 10'd1022;
  localparam dpram_addr_t dpram_a_last = 10'd1023;

  // refill cycles after a continuation request
  localparam logic [2:0] rd_wait_cnt_max = 3'd4;

  // header FIFO size, kept a power of two
  localparam int hdr_fifo_depth = 4;
  localparam int hdr_fifo_ptr_w = $clog2(hdr_fifo_depth);

  typedef enum logic [3:0] {
    s_idle,
    s_start_stream,
    s_chan_len,
    s_hdr_0_ltc_2,
    s_ltc_1_ltc_0,
    s_sample_word,
    s_ftr,
    s_ack,
    s_req_wait,
    s_rd_wait
  } rd_ctrl_state_t;

  typedef enum logic [1:0] {
    r_idle,
    r_wait_ack,
    r_wait_done
  } reader_state_t;

endpackage

//--- logic/wvb_rd_ctrl_fmt_0.sv
// format-0 read controller that writes header, sample and footer words into the readout DPRAM
`timescale 1ns/10ps
`default_nettype none

module wvb_rd_ctrl_fmt_0
  import wvb_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        req,
  input  wire chan_t       idx,
  input  wire logic        dpram_mode,
  input  wire wvb_sample_t wvb_data,
  input  wire wvb_hdr_t    hdr_data,
  output logic             ack,
  output logic             rd_ctrl_more,
  output logic             wvb_rdreq,
  output logic             wvb_rddone,
  output dpram_addr_t      dpram_a,
  output dpram_word_t      dpram_data,
  output logic             dpram_wren,
  output evt_len_t         dpram_len
);

  // header bundle fields
  ltc_t evt_ltc;
  wvb_addr_t start_addr;
  wvb_addr_t stop_addr;
  logic [4:0] pre_conf;
  logic cnst_run;
  logic [1:0] trig_src;
  wvb_addr_t addr_diff;
  evt_len_t evt_len;
  rd_word_t hdr_0;

  // sample fields
  logic [7:0] wvb_discr;
  logic [11:0] wvb_adc;
  rd_word_t wvb_adc_ext;
  logic wvb_tot;
  logic wvb_eoe;

  rd_ctrl_state_t state;
  // footer deferred to the next DPRAM
  logic loop_s_ftr;
  logic [2:0] wait_cnt;
  evt_len_t evt_len_reg;
  // kept since the header is popped before a deferred footer
  rd_word_t hdr_0_reg;

  assign {evt_ltc, start_addr, stop_addr, pre_conf, cnst_run, trig_src} = hdr_data;
  // address difference wraps with the circular memory
  assign addr_diff = stop_addr - start_addr;
  assign evt_len = evt_len_t'(addr_diff) + 16'd1;
  assign hdr_0 = {pre_conf, cnst_run, 8'b0, trig_src};

  assign {wvb_discr, wvb_adc, wvb_tot, wvb_eoe} = wvb_data;
  assign wvb_adc_ext = {{4{wvb_adc[11]}}, wvb_adc};

  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
      rd_ctrl_more <= 1'b0;
      wvb_rdreq <= 1'b0;
      wvb_rddone <= 1'b0;
      dpram_a <= '0;
      dpram_wren <= 1'b0;
      dpram_len <= '0;
      loop_s_ftr <= 1'b0;
      wait_cnt <= '0;
      state <= s_idle;
    end else begin
      // strobes default low
      ack <= 1'b0;
      dpram_wren <= 1'b0;
      wvb_rddone <= 1'b0;
      wvb_rdreq <= 1'b0;

      case (state)
        s_idle: begin
          dpram_a <= '0;
          dpram_len <= '0;
          rd_ctrl_more <= 1'b0;
          loop_s_ftr <= 1'b0;
          wait_cnt <= '0;
          if (req) begin
            // start the sample stream while the header words go out
            wvb_rdreq <= 1'b1;
            evt_len_reg <= evt_len;
            hdr_0_reg <= hdr_0;
            state <= s_start_stream;
          end
        end

        s_start_stream: begin
          wvb_rdreq <= 1'b1;
          state <= s_chan_len;
        end

        s_chan_len: begin
          // channel word in the low half, read first
          dpram_data <= {evt_len_reg, fmt_code, idx};
          wvb_rdreq <= 1'b1;
          dpram_wren <= 1'b1;
          state <= s_hdr_0_ltc_2;
        end

        s_hdr_0_ltc_2: begin
          dpram_data <= {evt_ltc[47:32], hdr_0_reg};
          wvb_rdreq <= 1'b1;
          dpram_wren <= 1'b1;
          dpram_a <= dpram_a + 1'b1;
          state <= s_ltc_1_ltc_0;
        end

        s_ltc_1_ltc_0: begin
          dpram_data <= {evt_ltc[15:0], evt_ltc[31:16]};
          wvb_rdreq <= 1'b1;
          dpram_wren <= 1'b1;
          dpram_a <= dpram_a + 1'b1;
          state <= s_sample_word;
        end

        s_sample_word: begin
          dpram_data <= {wvb_discr, 6'b0, wvb_tot, wvb_eoe, wvb_adc_ext};
          // stop reading near the DPRAM end, keep going when a new fill begins at the wrap
          if ((dpram_a < dpram_a_stop_stream) || (dpram_a == dpram_a_last)) begin
            wvb_rdreq <= 1'b1;
          end
          dpram_wren <= 1'b1;
          dpram_a <= dpram_a + 1'b1;

          if (!dpram_mode) begin
            // mode 0 ends at the EOE or truncates at the DPRAM end
            if (wvb_eoe || (dpram_a == dpram_a_last_data)) begin
              wvb_rddone <= 1'b1;
              state <= s_ftr;
            end
          end else if (wvb_eoe) begin
            wvb_rddone <= 1'b1;
            state <= s_ftr;
          end else if (dpram_a == dpram_a_last_data_continue) begin
            // DPRAM full, event goes on in the next fill
            rd_ctrl_more <= 1'b1;
            state <= s_ack;
          end
        end

        s_ftr: begin
          if ((dpram_a != dpram_a_last) || loop_s_ftr) begin
            dpram_data <= {hdr_0_reg, evt_len_reg};
            dpram_wren <= 1'b1;
            dpram_a <= dpram_a + 1'b1;
            loop_s_ftr <= 1'b0;
            rd_ctrl_more <= 1'b0;
          end else begin
            // no room for the footer, it opens the next fill
            loop_s_ftr <= 1'b1;
            rd_ctrl_more <= 1'b1;
          end
          state <= s_ack;
        end

        s_ack: begin
          // count of 16-bit words
          dpram_len <= (evt_len_t'(dpram_a) + 16'd1) << 1;
          ack <= 1'b1;
          if (!req) begin
            ack <= 1'b0;
            dpram_len <= '0;
            state <= rd_ctrl_more ? s_req_wait : s_idle;
          end
        end

        s_req_wait: begin
          if (req) begin
            if (loop_s_ftr) begin
              state <= s_ftr;
            end else begin
              wvb_rdreq <= 1'b1;
              wait_cnt <= '0;
              state <= s_rd_wait;
            end
          end
        end

        s_rd_wait: begin
          // refill the read pipeline before sampling again
          wait_cnt <= wait_cnt + 1'b1;
          wvb_rdreq <= 1'b1;
          if (wait_cnt == rd_wait_cnt_max) begin
            state <= s_sample_word;
          end
        end

        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/wvb_reader.sv
// readout requester that hands filled DPRAMs to the outside and re-requests continuation fills
`timescale 1ns/10ps
`default_nettype none

module wvb_reader
  import wvb_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     hdr_avail,
  input  wire logic     mode,
  input  wire logic     ack,
  input  wire logic     rd_ctrl_more,
  input  wire evt_len_t dpram_len,
  input  wire logic     dpram_done,
  output logic          req,
  output logic          dpram_mode,
  output logic          dpram_ready,
  output evt_len_t      dpram_len_out,
  output logic          dpram_more
);

  reader_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      req <= 1'b0;
      dpram_mode <= 1'b0;
      dpram_ready <= 1'b0;
      dpram_more <= 1'b0;
      state <= r_idle;
    end else begin
      case (state)
        r_idle: begin
          if (hdr_avail) begin
            // mode is fixed for the whole event
            req <= 1'b1;
            dpram_mode <= mode;
            state <= r_wait_ack;
          end
        end

        r_wait_ack: begin
          if (ack) begin
            // DPRAM belongs to the outside until dpram_done
            req <= 1'b0;
            dpram_ready <= 1'b1;
            dpram_len_out <= dpram_len;
            dpram_more <= rd_ctrl_more;
            state <= r_wait_done;
          end
        end

        r_wait_done: begin
          if (dpram_done) begin
            dpram_ready <= 1'b0;
            dpram_more <= 1'b0;
            if (dpram_more) begin
              // same event, next fill
              req <= 1'b1;
              state <= r_wait_ack;
            end else begin
              state <= r_idle;
            end
          end
        end

        default: begin
          state <= r_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/wvb_readout_top.sv
// top level of one readout channel with buffer, reader, read controller and DPRAM
`timescale 1ns/10ps
`default_nettype none

module wvb_readout_top
  import wvb_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire chan_t       chan_idx,
  input  wire logic        mode,
  input  wire logic        sample_wr,
  input  wire wvb_sample_t sample_data,
  input  wire logic        evt_end,
  input  wire ltc_t        ltc,
  input  wire logic [1:0]  trig_type,
  input  wire logic        cnst_run,
  input  wire logic [4:0]  pre_conf,
  input  wire rd_addr_t    rd_addr,
  input  wire logic        dpram_done,
  output rd_word_t         rd_data,
  output logic             dpram_ready,
  output evt_len_t         dpram_len,
  output logic             dpram_more
);

  // buffer side
  wvb_sample_t wvb_data;
  wvb_hdr_t hdr_data;
  logic hdr_avail;
  logic wvb_rdreq;
  logic wvb_rddone;

  // reader to controller
  logic req;
  logic ack;
  logic rd_ctrl_more;
  logic dpram_mode;
  evt_len_t ctrl_len;

  // controller to DPRAM
  dpram_addr_t dpram_a;
  dpram_word_t dpram_data;
  logic dpram_wren;

  wvb_buffer buffer (
    .clk         (clk),
    .rst         (rst),
    .sample_wr   (sample_wr),
    .sample_data (sample_data),
    .evt_end     (evt_end),
    .ltc         (ltc),
    .trig_type   (trig_type),
    .cnst_run    (cnst_run),
    .pre_conf    (pre_conf),
    .wvb_rdreq   (wvb_rdreq),
    .wvb_rddone  (wvb_rddone),
    .wvb_data    (wvb_data),
    .hdr_data    (hdr_data),
    .hdr_avail   (hdr_avail)
  );

  wvb_reader reader (
    .clk           (clk),
    .rst           (rst),
    .hdr_avail     (hdr_avail),
    .mode          (mode),
    .ack           (ack),
    .rd_ctrl_more  (rd_ctrl_more),
    .dpram_len     (ctrl_len),
    .dpram_done    (dpram_done),
    .req           (req),
    .dpram_mode    (dpram_mode),
    .dpram_ready   (dpram_ready),
    .dpram_len_out (dpram_len),
    .dpram_more    (dpram_more)
  );

  wvb_rd_ctrl_fmt_0 rd_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .idx          (chan_idx),
    .dpram_mode   (dpram_mode),
    .wvb_data     (wvb_data),
    .hdr_data     (hdr_data),
    .ack          (ack),
    .rd_ctrl_more (rd_ctrl_more),
    .wvb_rdreq    (wvb_rdreq),
    .wvb_rddone   (wvb_rddone),
    .dpram_a      (dpram_a),
    .dpram_data   (dpram_data),
    .dpram_wren   (dpram_wren),
    .dpram_len    (ctrl_len)
  );

  dpram_readout dpram (
    .clk     (clk),
    .wren    (dpram_wren),
    .wr_addr (dpram_a),
    .wr_data (dpram_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

//--- testbench/wvb_readout_tb.sv
// table-driven testbench for the waveform readout channel with an event model and typed compare tasks
`timescale 1ns/10ps
`default_nettype none

module wvb_readout_tb
  import wvb_pkg::*;
();

  localparam int n_evt = 9;
  localparam chan_t test_chan = 8'h2b;
  // last 32-bit word that may hold a sample, per mode
  localparam int m0_last_word = 1022;
  localparam int last_word = 1023;
  localparam int ready_timeout = 6000;

  // event table: 6 to 8 go out back-to-back, 6 and 7 hold their readout
  int tbl_n [n_evt] = '{5, 6, 1500, 1500, 1021, 1019, 3, 4, 7};
  logic tbl_mode [n_evt] = '{0, 0, 0, 1, 1, 1, 0, 0, 0};
  logic tbl_neg [n_evt] = '{0, 1, 0, 0, 0, 0, 0, 1, 0};
  logic tbl_hold [n_evt] = '{0, 0, 0, 0, 0, 0, 1, 1, 0};
  ltc_t tbl_ltc [n_evt] = '{48'h1234_5678_9abc, 48'h0000_0000_0001, 48'hffff_0000_ffff,
                            48'h0a0b_0c0d_0e0f, 48'h8000_0000_0000, 48'h7fff_ffff_fffe,
                            48'h1111_2222_3333, 48'h4444_5555_6666, 48'h7777_8888_9999};
  logic [1:0] tbl_trig [n_evt] = '{2'd1, 2'd2, 2'd3, 2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd1};
  logic tbl_cnst [n_evt] = '{0, 1, 0, 1, 0, 1, 1, 0, 1};
  logic [4:0] tbl_pre [n_evt] = '{5'h01, 5'h1f, 5'h0a, 5'h15, 5'h03, 5'h10, 5'h07, 5'h18, 5'h0c};

  // DUT signals
  logic clk;
  logic rst;
  chan_t chan_idx;
  logic mode;
  logic sample_wr;
  wvb_sample_t sample_data;
  logic evt_end;
  ltc_t ltc;
  logic [1:0] trig_type;
  logic cnst_run;
  logic [4:0] pre_conf;
  rd_addr_t rd_addr;
  logic dpram_done;
  rd_word_t rd_data;
  logic dpram_ready;
  evt_len_t dpram_len;
  logic dpram_more;

  // copy of every sample written, indexed from each event's base
  wvb_sample_t smp [8192];
  int evt_base [n_evt];
  int smp_top;

  // expected content of one DPRAM fill
  rd_word_t exp_words [2048];
  int exp_len;
  logic exp_more;
  int cur_smp;
  logic ftr_pending;

  int seed;
  int n_checks;
  int n_mismatch;
  int n_fault;
  logic timed_out;
  int pending [$];

  wvb_readout_top DUT (
    .clk         (clk),
    .rst         (rst),
    .chan_idx    (chan_idx),
    .mode        (mode),
    .sample_wr   (sample_wr),
    .sample_data (sample_data),
    .evt_end     (evt_end),
    .ltc         (ltc),
    .trig_type   (trig_type),
    .cnst_run    (cnst_run),
    .pre_conf    (pre_conf),
    .rd_addr     (rd_addr),
    .dpram_done  (dpram_done),
    .rd_data     (rd_data),
    .dpram_ready (dpram_ready),
    .dpram_len   (dpram_len),
    .dpram_more  (dpram_more)
  );

  always #4 clk = ~clk;

  task automatic check_word(input string name, input rd_word_t exp, input rd_word_t act);
    n_checks++;
    if (exp !== act) begin
      n_mismatch++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_len(input string name, input evt_len_t exp, input evt_len_t act);
    n_checks++;
    if (exp !== act) begin
      n_mismatch++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_more(input string name, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_mismatch++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // one sample per cycle, header fields ride on the final sample
  task automatic write_event(input int e);
    logic [11:0] adc;
    logic [7:0] discr;
    wvb_sample_t s;
    mode = tbl_mode[e];
    ltc = tbl_ltc[e];
    trig_type = tbl_trig[e];
    cnst_run = tbl_cnst[e];
    pre_conf = tbl_pre[e];
    evt_base[e] = smp_top;
    for (int i = 0; i < tbl_n[e]; i++) begin
      adc = $random(seed);
      discr = $random(seed);
      if (tbl_neg[e]) begin
        adc[11] = 1'b1;
      end
      // discr, adc, tot from the adc low bit, eoe on the last sample
      s = {discr, adc, adc[0], (i == tbl_n[e] - 1)};
      smp[smp_top] = s;
      smp_top++;
      @(posedge clk);
      #1;
      sample_wr = 1'b1;
      sample_data = s;
      evt_end = (i == tbl_n[e] - 1);
    end
    @(posedge clk);
    #1;
    sample_wr = 1'b0;
    evt_end = 1'b0;
  endtask

  // expected words of the next fill, following the format-0 layout
  task automatic build_fill(input int e);
    int p;
    int n;
    int last;
    wvb_sample_t s;
    rd_word_t h0;
    n = tbl_n[e];
    h0 = {tbl_pre[e], tbl_cnst[e], 8'h00, tbl_trig[e]};
    p = 0;
    // only the first fill carries the channel word, length, header and ltc
    if (cur_smp == 0 && !ftr_pending) begin
      exp_words[0] = {fmt_code, test_chan};
      exp_words[1] = evt_len_t'(n);
      exp_words[2] = h0;
      exp_words[3] = tbl_ltc[e][47:32];
      exp_words[4] = tbl_ltc[e][31:16];
      exp_words[5] = tbl_ltc[e][15:0];
      p = 3;
    end
    if (!ftr_pending) begin
      last = tbl_mode[e] ? last_word : m0_last_word;
      while (cur_smp < n && p <= last) begin
        s = smp[evt_base[e] + cur_smp];
        // sign-extended adc in the low half, discr/tot/eoe in the high half
        exp_words[2 * p] = {{4{s[13]}}, s[13:2]};
        exp_words[2 * p + 1] = {s[21:14], 6'b0, s[1], s[0]};
        cur_smp++;
        p++;
      end
      // mode 0 drops whatever did not fit
      if (!tbl_mode[e]) begin
        cur_smp = n;
      end
    end
    if (cur_smp == n && p <= last_word) begin
      exp_words[2 * p] = evt_len_t'(n);
      exp_words[2 * p + 1] = h0;
      p++;
      exp_more = 1'b0;
      ftr_pending = 1'b0;
    end else begin
      // DPRAM full; either samples or only the footer remain
      exp_more = 1'b1;
      ftr_pending = (cur_smp == n);
    end
    exp_len = 2 * p;
  endtask

  task automatic wait_ready(input int e);
    int cnt;
    cnt = 0;
    while (!dpram_ready && cnt < ready_timeout) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!dpram_ready) begin
      n_fault++;
      timed_out = 1'b1;
      $display("timeout: dpram_ready never rose for event %0d", e);
    end
  endtask

  // rd_data shows the word one cycle after its address
  task automatic compare_fill(input int e, input int fill);
    rd_addr = '0;
    for (int i = 0; i < exp_len; i++) begin
      @(posedge clk);
      #1;
      check_word($sformatf("evt%0d fill%0d word%0d", e, fill, i), exp_words[i], rd_data);
      rd_addr = rd_addr_t'(i + 1);
    end
  endtask

  task automatic pulse_done();
    @(posedge clk);
    #1;
    dpram_done = 1'b1;
    @(posedge clk);
    #1;
    dpram_done = 1'b0;
    if (dpram_ready) begin
      n_fault++;
      $display("dpram_ready stayed high after dpram_done");
    end
  endtask

  task automatic read_event(input int e);
    int fill;
    cur_smp = 0;
    ftr_pending = 1'b0;
    fill = 0;
    do begin
      build_fill(e);
      wait_ready(e);
      if (timed_out) begin
        return;
      end
      // mode goes back to the event's own value once the fill is handed over
      mode = tbl_mode[e];
      check_len($sformatf("evt%0d fill%0d dpram_len", e, fill), evt_len_t'(exp_len), dpram_len);
      check_more($sformatf("evt%0d fill%0d dpram_more", e, fill), exp_more, dpram_more);
      compare_fill(e, fill);
      // a mode change before a continuation fill must not alter the event
      if (exp_more) begin
        mode = !tbl_mode[e];
      end
      pulse_done();
      fill++;
    end while (exp_more && fill < 4);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    chan_idx = test_chan;
    mode = 1'b0;
    sample_wr = 1'b0;
    sample_data = '0;
    evt_end = 1'b0;
    ltc = '0;
    trig_type = '0;
    cnst_run = 1'b0;
    pre_conf = '0;
    rd_addr = '0;
    dpram_done = 1'b0;
    seed = 32'hd697;
    smp_top = 0;
    n_checks = 0;
    n_mismatch = 0;
    n_fault = 0;
    timed_out = 1'b0;

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check_more("reset dpram_ready", 1'b0, dpram_ready);
    check_more("reset dpram_more", 1'b0, dpram_more);

    // held events queue up in the DUT until a non-held one triggers readout
    for (int e = 0; e < n_evt && !timed_out; e++) begin
      write_event(e);
      pending.push_back(e);
      if (!tbl_hold[e]) begin
        while (pending.size() > 0 && !timed_out) begin
          read_event(pending.pop_front());
        end
      end
    end

    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_fault);
    if (n_mismatch == 0 && n_fault == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
